// File: vlog.f
design/t07Pkg.sv
design/t07Mmio.sv
design/t07WishboneManager.sv
design/t07WishboneDecoder.sv
design/t07Sram.sv
design/t07Top.sv
tests/t07TopTb.sv

// File: Bender.yml
package:
  name: t07_mem_path

sources:
  - files:
      - design/t07Pkg.sv
      - design/t07Mmio.sv
      - design/t07WishboneManager.sv
      - design/t07WishboneDecoder.sv
      - design/t07Sram.sv
      - design/t07Top.sv
  - target: test
    files:
      - tests/t07TopTb.sv

// File: tests/t07TopTb.sv
`timescale 1ns/1ps
`default_nettype none

module t07TopTb;

    localparam int Timeout   = 20;
    // busy cycles seen at the top level per access kind
    localparam int LocalBusy = 1;
    localparam int SramBusy  = 3;
    localparam int UnmapBusy = 2;

    typedef struct packed {
        t07Pkg::t07Word data;
        logic           err;
        logic [7:0]     led;
        logic [7:0]     cycles;
    } accessResult;

    logic           clk;
    logic           reset;
    t07Pkg::t07Rwi  rwi;
    t07Pkg::t07Addr addr;
    t07Pkg::t07Word writeData;
    t07Pkg::t07Word readData;
    logic           busy;
    logic           invalError;
    logic [7:0]     ledOut;

    // reference memory map
    t07Pkg::t07Word bank0 [t07Pkg::SramWords];
    t07Pkg::t07Word bank1 [t07Pkg::SramWords];
    t07Pkg::t07Word regs [4];
    t07Pkg::t07Word lastRead;
    logic           stickyErr;

    integer         seed = 83;
    int             checkCount;
    int             errorCount;
    int             testErrors;
    string          label;
    accessResult    expRes;
    accessResult    gotRes;
    event           accessDone;
    t07Pkg::t07Addr addrList [$];

    t07Top u_t07Top (
        .clk        (clk),
        .reset      (reset),
        .rwi        (rwi),
        .addr       (addr),
        .writeData  (writeData),
        .readData   (readData),
        .busy       (busy),
        .invalError (invalError),
        .ledOut     (ledOut)
    );

    always #2 clk = ~clk;

    // expected readData, error flag, led byte and busy length after one access
    function automatic accessResult predict(input t07Pkg::t07Rwi cmd,
                                            input t07Pkg::t07Addr a,
                                            input t07Pkg::t07Word d);
        accessResult    r;
        t07Pkg::t07Addr offM;
        t07Pkg::t07Addr off0;
        t07Pkg::t07Addr off1;
        offM = a - t07Pkg::MmioBase;
        off0 = a - t07Pkg::Sram0Base;
        off1 = a - t07Pkg::Sram1Base;
        if (offM < 16) begin
            r.cycles = LocalBusy;
            if (cmd == t07Pkg::rwiWrite) begin
                regs[offM[3:2]] = d;
            end else begin
                lastRead = regs[offM[3:2]];
            end
        end else if (off0 < t07Pkg::SramWords * 4) begin
            r.cycles = SramBusy;
            if (cmd == t07Pkg::rwiWrite) begin
                bank0[(off0 >> 2) % t07Pkg::SramWords] = d;
            end else begin
                lastRead = bank0[(off0 >> 2) % t07Pkg::SramWords];
            end
        end else if (off1 < t07Pkg::SramWords * 4) begin
            r.cycles = SramBusy;
            if (cmd == t07Pkg::rwiWrite) begin
                bank1[(off1 >> 2) % t07Pkg::SramWords] = d;
            end else begin
                lastRead = bank1[(off1 >> 2) % t07Pkg::SramWords];
            end
        end else begin
            // unmapped reads as zero and sets the sticky error
            r.cycles  = UnmapBusy;
            stickyErr = 1'b1;
            if (cmd == t07Pkg::rwiRead) begin
                lastRead = '0;
            end
        end
        r.data = lastRead;
        r.err  = stickyErr;
        r.led  = regs[0][7:0];
        return r;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0.1f ns: %s is %h, expected %h", $realtime, what, got, exp);
        end
    endtask

    always @(accessDone) begin
        checkValue({label, " readData"}, gotRes.data, expRes.data);
        checkValue({label, " invalError"}, gotRes.err, expRes.err);
        checkValue({label, " ledOut"}, gotRes.led, expRes.led);
        checkValue({label, " busy cycles"}, gotRes.cycles, expRes.cycles);
    end

    // optionally fires a second write while the first access is still busy
    task automatic access(input t07Pkg::t07Rwi cmd, input t07Pkg::t07Addr a,
                          input t07Pkg::t07Word d, input bit inject,
                          input t07Pkg::t07Addr injAddr, input t07Pkg::t07Word injData);
        int cycles;
        @(posedge clk);
        #0.5;
        rwi       = cmd;
        addr      = a;
        writeData = d;
        @(posedge clk);
        #0.5;
        cycles = 0;
        while (busy && cycles < Timeout) begin
            if (inject && cycles == 0) begin
                rwi       = t07Pkg::rwiWrite;
                addr      = injAddr;
                writeData = injData;
            end else begin
                rwi = t07Pkg::rwiIdle;
            end
            cycles++;
            @(posedge clk);
            #0.5;
        end
        rwi = t07Pkg::rwiIdle;
        if (busy) begin
            $display("timeout: busy still high %0d cycles after access to %h", Timeout, a);
            $display("Test FAILED");
            $finish;
        end else begin
            label  = $sformatf("%s %h", (cmd == t07Pkg::rwiWrite) ? "write" : "read", a);
            expRes = predict(cmd, a, d);
            gotRes = '{data: readData, err: invalError, led: ledOut, cycles: cycles[7:0]};
            -> accessDone;
        end
    endtask

    task automatic writeWord(input t07Pkg::t07Addr a, input t07Pkg::t07Word d);
        access(t07Pkg::rwiWrite, a, d, 1'b0, '0, '0);
    endtask

    task automatic readWord(input t07Pkg::t07Addr a);
        access(t07Pkg::rwiRead, a, '0, 1'b0, '0, '0);
    endtask

    task automatic applyReset();
        reset = 1'b1;
        rwi   = t07Pkg::rwiIdle;
        repeat (8) @(posedge clk);
        #0.5;
        reset     = 1'b0;
        stickyErr = 1'b0;
        lastRead  = '0;
        for (int i = 0; i < 4; i++) begin
            regs[i] = '0;
        end
    endtask

    // one clock lets the checker settle before the verdict
    task automatic finishTest(input string name);
        @(posedge clk);
        #0.5;
        if (errorCount == testErrors) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d errors", name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    initial begin
        t07Pkg::t07Addr a;
        t07Pkg::t07Addr b;
        int             off;
        clk        = 1'b0;
        reset      = 1'b1;
        rwi        = t07Pkg::rwiIdle;
        addr       = '0;
        writeData  = '0;
        checkCount = 0;
        errorCount = 0;
        testErrors = 0;
        applyReset();

        checkValue("reset busy", busy, 0);
        checkValue("reset invalError", invalError, 0);
        checkValue("reset ledOut", ledOut, 0);
        checkValue("reset readData", readData, 0);
        finishTest("reset state");

        // alternate banks and read back only written words
        for (int i = 0; i < 24; i++) begin
            off = $unsigned($random(seed)) % t07Pkg::SramWords;
            a   = ((i % 2) ? t07Pkg::Sram1Base : t07Pkg::Sram0Base) + off * 4;
            writeWord(a, $random(seed));
            addrList.push_back(a);
        end
        foreach (addrList[i]) begin
            readWord(addrList[i]);
        end
        finishTest("sram random");

        for (int i = 0; i < 4; i++) begin
            writeWord(t07Pkg::MmioBase + i * 4, $random(seed));
        end
        for (int i = 0; i < 4; i++) begin
            readWord(t07Pkg::MmioBase + i * 4);
        end
        writeWord(t07Pkg::MmioBase, 32'h0000_00A5);
        readWord(t07Pkg::MmioBase);
        finishTest("local registers");

        // write to b while a read of a is in flight must be dropped
        a = t07Pkg::Sram0Base + ($unsigned($random(seed)) % t07Pkg::SramWords) * 4;
        b = a ^ 32'h4;
        writeWord(a, $random(seed));
        writeWord(b, $random(seed));
        access(t07Pkg::rwiRead, a, '0, 1'b1, b, $random(seed));
        readWord(b);
        readWord(a);
        finishTest("ignored command");

        off = $unsigned($random(seed)) % t07Pkg::SramWords;
        writeWord(t07Pkg::Sram0Base + off * 4, $random(seed));
        writeWord(t07Pkg::Sram1Base + off * 4, $random(seed));
        readWord(t07Pkg::Sram0Base + off * 4);
        readWord(t07Pkg::Sram1Base + off * 4);
        finishTest("bank select");

        readWord(32'h0000_2000);
        writeWord(32'h8000_0000, $random(seed));
        readWord(addrList[0]);
        writeWord(t07Pkg::MmioBase + 4, $random(seed));
        readWord(t07Pkg::MmioBase + 4);
        applyReset();
        checkValue("invalError after reset", invalError, 0);
        readWord(addrList[1]);
        finishTest("unmapped access");

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/t07Top.sv
`timescale 1ns/1ps
`default_nettype none

module t07Top (
    input  logic           clk,
    input  logic           reset,
    input  t07Pkg::t07Rwi  rwi,
    input  t07Pkg::t07Addr addr,
    input  t07Pkg::t07Word writeData,
    output t07Pkg::t07Word readData,
    output logic           busy,
    output logic           invalError,
    output logic [7:0]     ledOut
);

    // mmio to manager
    t07Pkg::t07WbReq mmioReq;
    t07Pkg::t07WbRsp mgrRsp;
    logic            start;
    logic            done;

    // manager to decoder
    t07Pkg::t07WbReq busReq;
    t07Pkg::t07WbRsp busRsp;

    // decoder to the banks
    t07Pkg::t07WbReq sramReq0;
    t07Pkg::t07WbReq sramReq1;
    t07Pkg::t07WbRsp sramRsp0;
    t07Pkg::t07WbRsp sramRsp1;

    t07Mmio u_mmio (
        .clk        (clk),
        .reset      (reset),
        .rwi        (rwi),
        .addr       (addr),
        .writeData  (writeData),
        .readData   (readData),
        .busy       (busy),
        .invalError (invalError),
        .ledOut     (ledOut),
        .busReq     (mmioReq),
        .start      (start),
        .done       (done),
        .busRsp     (mgrRsp)
    );

    t07WishboneManager u_manager (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .cpuReq (mmioReq),
        .done   (done),
        .cpuRsp (mgrRsp),
        .wbReq  (busReq),
        .wbRsp  (busRsp)
    );

    t07WishboneDecoder u_decoder (
        .req      (busReq),
        .sramReq0 (sramReq0),
        .sramReq1 (sramReq1),
        .sramRsp0 (sramRsp0),
        .sramRsp1 (sramRsp1),
        .rsp      (busRsp)
    );

    t07Sram #(.Words(t07Pkg::SramWords)) u_sram0 (
        .clk   (clk),
        .reset (reset),
        .req   (sramReq0),
        .rsp   (sramRsp0)
    );

    t07Sram #(.Words(t07Pkg::SramWords)) u_sram1 (
        .clk   (clk),
        .reset (reset),
        .req   (sramReq1),
        .rsp   (sramRsp1)
    );

endmodule

`default_nettype wire

// File: design/t07Sram.sv
`timescale 1ns/1ps
`default_nettype none

module t07Sram #(
    parameter int Words = 256
) (
    input  logic            clk,
    input  logic            reset,
    input  t07Pkg::t07WbReq req,
    output t07Pkg::t07WbRsp rsp
);

    localparam int IdxBits = $clog2(Words);

    t07Pkg::t07Word     mem [Words];
    logic [IdxBits-1:0] idx;
    logic               ackReg;
    t07Pkg::t07Word     datReg;
    logic               hit;

    // word index wraps at the bank size
    assign idx = req.adr[IdxBits+1:2];

    // first cycle of a strobe not yet acknowledged
    assign hit = req.cyc && req.stb && !ackReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            ackReg <= 1'b0;
        end else begin
            ackReg <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (req.we) begin
                mem[idx] <= req.dat;
            end
            datReg <= mem[idx];
        end
    end

    assign rsp = '{ack: ackReg, err: 1'b0, dat: datReg};

endmodule

`default_nettype wire

// File: design/t07WishboneDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module t07WishboneDecoder (
    input  t07Pkg::t07WbReq req,
    output t07Pkg::t07WbReq sramReq0,
    output t07Pkg::t07WbReq sramReq1,
    input  t07Pkg::t07WbRsp sramRsp0,
    input  t07Pkg::t07WbRsp sramRsp1,
    output t07Pkg::t07WbRsp rsp
);

    logic           sel0;
    logic           sel1;
    logic           active;

    // unsigned offset compare covers both bounds at once
    assign sel0   = (req.adr - t07Pkg::Sram0Base) < t07Pkg::t07Addr'(t07Pkg::SramWords * 4);
    assign sel1   = (req.adr - t07Pkg::Sram1Base) < t07Pkg::t07Addr'(t07Pkg::SramWords * 4);
    assign active = req.cyc && req.stb;

    // only the matching bank sees cyc and stb
    always_comb begin
        sramReq0     = req;
        sramReq1     = req;
        sramReq0.cyc = req.cyc && sel0;
        sramReq0.stb = req.stb && sel0;
        sramReq1.cyc = req.cyc && sel1 && !sel0;
        sramReq1.stb = req.stb && sel1 && !sel0;
    end

    always_comb begin
        if (sel0) begin
            rsp = sramRsp0;
        end else if (sel1) begin
            rsp = sramRsp1;
        end else begin
            // unmapped address answers at once with an error
            rsp = '{ack: active, err: active, dat: '0};
        end
    end

endmodule

`default_nettype wire

// File: design/t07WishboneManager.sv
`timescale 1ns/1ps
`default_nettype none

module t07WishboneManager (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  t07Pkg::t07WbReq cpuReq,
    output logic            done,
    output t07Pkg::t07WbRsp cpuRsp,
    output t07Pkg::t07WbReq wbReq,
    input  t07Pkg::t07WbRsp wbRsp
);

    typedef enum logic [1:0] {
        mgrIdle,
        mgrBus,
        mgrDone
    } mgrState;

    mgrState         state;
    t07Pkg::t07WbReq reqReg;
    logic            inBus;

    assign inBus = state == mgrBus;

    // completion is seen in the same cycle as ack
    assign done = inBus && wbRsp.ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mgrIdle;
        end else begin
            case (state)
                // mgrDone is the turnaround cycle with cyc low
                mgrIdle, mgrDone: begin
                    state <= start ? mgrBus : mgrIdle;
                end
                mgrBus: begin
                    if (wbRsp.ack) begin
                        state <= mgrDone;
                    end
                end
                default: begin
                    state <= mgrIdle;
                end
            endcase
        end
    end

    // request latch
    always_ff @(posedge clk) begin
        if (start && !inBus) begin
            reqReg <= cpuReq;
        end
    end

    // cyc and stb follow the bus state
    always_comb begin
        wbReq     = reqReg;
        wbReq.cyc = inBus;
        wbReq.stb = inBus;
    end

    // live slave response goes back with done as its ack
    always_comb begin
        cpuRsp     = wbRsp;
        cpuRsp.ack = done;
    end

endmodule

`default_nettype wire

// File: design/t07Mmio.sv
`timescale 1ns/1ps
`default_nettype none

module t07Mmio (
    input  logic            clk,
    input  logic            reset,
    input  t07Pkg::t07Rwi   rwi,
    input  t07Pkg::t07Addr  addr,
    input  t07Pkg::t07Word  writeData,
    output t07Pkg::t07Word  readData,
    output logic            busy,
    output logic            invalError,
    output logic [7:0]      ledOut,
    output t07Pkg::t07WbReq busReq,
    output logic            start,
    input  logic            done,
    input  t07Pkg::t07WbRsp busRsp
);

    t07Pkg::t07Word localRegs [4];
    logic           accept;
    logic           isLocal;
    logic [1:0]     regIdx;
    logic           localPending;
    logic           readPending;

    // a command is taken only while idle
    assign accept  = (rwi != t07Pkg::rwiIdle) && !busy;
    assign isLocal = addr[31:4] == t07Pkg::MmioBase[31:4];
    assign regIdx  = addr[3:2];

    assign ledOut = localRegs[0][7:0];

    // everything outside the local bank goes to the bus in the cycle after acceptance
    always_ff @(posedge clk) begin
        if (reset) begin
            start  <= 1'b0;
            busReq <= '0;
        end else begin
            start <= accept && !isLocal;
            if (accept && !isLocal) begin
                busReq <= '{
                    cyc: 1'b1,
                    stb: 1'b1,
                    we:  rwi == t07Pkg::rwiWrite,
                    adr: addr,
                    dat: writeData
                };
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy         <= 1'b0;
            localPending <= 1'b0;
            readPending  <= 1'b0;
            invalError   <= 1'b0;
            readData     <= '0;
            for (int i = 0; i < 4; i++) begin
                localRegs[i] <= '0;
            end
        end else begin
            if (accept) begin
                busy         <= 1'b1;
                localPending <= isLocal;
                readPending  <= rwi == t07Pkg::rwiRead;
                if (isLocal) begin
                    if (rwi == t07Pkg::rwiWrite) begin
                        localRegs[regIdx] <= writeData;
                    end else begin
                        readData <= localRegs[regIdx];
                    end
                end
            end else if (localPending) begin
                // local access takes a single busy cycle
                busy         <= 1'b0;
                localPending <= 1'b0;
            end else if (done) begin
                busy <= 1'b0;
                if (readPending) begin
                    readData <= busRsp.dat;
                end
                // sticky until reset
                if (busRsp.err) begin
                    invalError <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/t07Pkg.sv
`default_nettype none

package t07Pkg;

    // data word and byte address
    typedef logic [31:0] t07Word;
    typedef logic [31:0] t07Addr;

    // CPU command codes
    typedef enum logic [1:0] {
        rwiIdle  = 2'b00,
        rwiWrite = 2'b01,
        rwiRead  = 2'b10
    } t07Rwi;

    // wishbone request for a full word
    typedef struct packed {
        logic   cyc;
        logic   stb;
        logic   we;
        t07Addr adr;
        t07Word dat;
    } t07WbReq;

    // wishbone response
    typedef struct packed {
        logic   ack;
        logic   err;
        t07Word dat;
    } t07WbRsp;

    // words per SRAM bank
    localparam int SramWords = 256;

    // memory map
    localparam t07Addr Sram0Base = 32'h0000_0000;
    localparam t07Addr Sram1Base = 32'h0000_0400;
    // four local registers at word offsets 0 to 3
    localparam t07Addr MmioBase  = 32'hFFFF_0000;

endpackage

`default_nettype wire
